// File: verilog/desc_proc_pkg.sv
package desc_proc_pkg;

    // --------------------
    // Bus and register map
    // --------------------
    localparam int unsigned data_width = 32;

    localparam logic [data_width-1:0] radio_base_addr  = 32'h6000_0000;
    localparam logic [data_width-1:0] async_cause_addr = radio_base_addr + 32'h0000_4038;
    localparam logic [data_width-1:0] isr_addr         = radio_base_addr + 32'h0000_0080;

    // Cause and ISR bits
    localparam logic [data_width-1:0] mac_irq_mask = 32'h0000_0002;
    // HP and LP receive OK
    localparam logic [data_width-1:0] rx_ok_mask   = 32'h0000_0003;

    // --------------------
    // Receive descriptor layout
    // --------------------
    // Status word 11
    localparam logic [data_width-1:0] rx_status_offset = 32'd44;
    localparam logic [data_width-1:0] rx_done_mask     = 32'h0000_0001;
    // Word 12, frame control in low half
    localparam logic [data_width-1:0] rx_fctl_offset   = 32'd48;

    // Frame type and subtype
    localparam logic [15:0] fctl_type_mask  = 16'h00fc;
    localparam logic [15:0] fctl_tdma_value = 16'h0004;

    // --------------------
    // State and opcode types
    // --------------------
    typedef enum logic [3:0] {
        irq_idle,
        irq_rd_cause,
        irq_rd_isr,
        irq_check_fifo,
        irq_rd_status,
        irq_rd_fctl,
        irq_dequeue,
        irq_decide,
        irq_pass
    } irq_state_t;

    typedef enum logic [1:0] {
        fetch_idle,
        fetch_addr,
        fetch_data,
        fetch_write
    } fetch_state_t;

    typedef enum logic {
        bus_read,
        bus_write
    } bus_op_t;

endpackage

// File: verilog/tx_desc_fetch.sv
`timescale 1ns/1ps

module tx_desc_fetch
    import desc_proc_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,

    // Transmit descriptor FIFO, first word fall through
    input  logic                  tx_fifo_empty,
    input  logic [data_width-1:0] tx_fifo_data,
    output logic                  tx_fifo_rd_en,

    // Write client toward the arbiter
    output logic                  wr_req,
    output logic [data_width-1:0] wr_addr,
    output logic [data_width-1:0] wr_data,
    input  logic                  wr_done
);

    fetch_state_t state;

    // Held high until the arbiter reports completion
    assign wr_req = (state == fetch_write);

    // --------------------
    // Fetch FSM
    // --------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state         <= fetch_idle;
            tx_fifo_rd_en <= 1'b0;
        end else begin
            tx_fifo_rd_en <= 1'b0;
            case (state)
                fetch_idle: begin
                    // Address word sits at the head
                    if (!tx_fifo_empty) begin
                        tx_fifo_rd_en <= 1'b1;
                        state         <= fetch_addr;
                    end
                end
                fetch_addr: begin
                    // Pop of the address word takes effect here
                    state <= fetch_data;
                end
                fetch_data: begin
                    // Host may still be pushing the data half
                    if (!tx_fifo_empty) begin
                        tx_fifo_rd_en <= 1'b1;
                        state         <= fetch_write;
                    end
                end
                fetch_write: begin
                    if (wr_done) begin
                        state <= fetch_idle;
                    end
                end
                default: begin
                    state <= fetch_idle;
                end
            endcase
        end
    end

    // Pair capture
    always_ff @(posedge clk) begin
        if (state == fetch_idle && !tx_fifo_empty) begin
            wr_addr <= tx_fifo_data;
        end
        if (state == fetch_data && !tx_fifo_empty) begin
            wr_data <= tx_fifo_data;
        end
    end

endmodule

// File: verilog/irq_filter.sv
`timescale 1ns/1ps

module irq_filter
    import desc_proc_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,

    // Radio interrupt in, host interrupt out
    input  logic                  irq_in,
    output logic                  irq_out,
    output logic                  tdma_event,

    // Receive buffer address FIFO
    input  logic                  rx_fifo_empty,
    input  logic [data_width-1:0] rx_fifo_data,
    output logic                  rx_fifo_rd_en,

    // Read client toward the arbiter
    output logic                  rd_req,
    output logic [data_width-1:0] rd_addr,
    input  logic                  rd_done,
    input  logic [data_width-1:0] rd_data
);

    irq_state_t state;
    irq_state_t state_next;

    logic                  irq_in_d;
    logic                  irq_pending;
    logic [data_width-1:0] buf_addr;
    logic [15:0]           fctl;
    logic                  is_tdma;

    // --------------------
    // Interrupt edge capture
    // --------------------
    // Pending is consumed when the FSM leaves idle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            irq_in_d    <= 1'b0;
            irq_pending <= 1'b0;
        end else begin
            irq_in_d    <= irq_in;
            irq_pending <= (irq_in && !irq_in_d) || (irq_pending && state != irq_idle);
        end
    end

    // TDMA control frame check on the captured frame control
    assign is_tdma = ((fctl & fctl_type_mask) == fctl_tdma_value);

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        state_next = state;
        case (state)
            irq_idle: begin
                if (irq_pending) begin
                    state_next = irq_rd_cause;
                end
            end
            irq_rd_cause: begin
                if (rd_done) begin
                    state_next = ((rd_data & mac_irq_mask) != '0) ? irq_rd_isr : irq_pass;
                end
            end
            irq_rd_isr: begin
                if (rd_done) begin
                    state_next = ((rd_data & rx_ok_mask) != '0) ? irq_check_fifo : irq_pass;
                end
            end
            irq_check_fifo: begin
                // Nothing queued, let the host sort it out
                state_next = rx_fifo_empty ? irq_pass : irq_rd_status;
            end
            irq_rd_status: begin
                if (rd_done) begin
                    state_next = ((rd_data & rx_done_mask) != '0) ? irq_rd_fctl : irq_pass;
                end
            end
            irq_rd_fctl: begin
                if (rd_done) begin
                    state_next = irq_dequeue;
                end
            end
            irq_dequeue: begin
                state_next = irq_decide;
            end
            irq_decide: begin
                // Swallow TDMA frames and look at the next buffer
                state_next = is_tdma ? irq_check_fifo : irq_pass;
            end
            irq_pass: begin
                if (!irq_in) begin
                    state_next = irq_idle;
                end
            end
            default: begin
                state_next = irq_idle;
            end
        endcase
    end

    // --------------------
    // Read requests
    // --------------------
    assign rd_req = (state == irq_rd_cause) || (state == irq_rd_isr) ||
                    (state == irq_rd_status) || (state == irq_rd_fctl);

    always_comb begin
        case (state)
            irq_rd_cause:  rd_addr = async_cause_addr;
            irq_rd_isr:    rd_addr = isr_addr;
            irq_rd_status: rd_addr = buf_addr + rx_status_offset;
            irq_rd_fctl:   rd_addr = buf_addr + rx_fctl_offset;
            default:       rd_addr = async_cause_addr;
        endcase
    end

    // --------------------
    // State and registered outputs
    // --------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state         <= irq_idle;
            irq_out       <= 1'b0;
            rx_fifo_rd_en <= 1'b0;
            tdma_event    <= 1'b0;
        end else begin
            state         <= state_next;
            irq_out       <= (state_next == irq_pass);
            rx_fifo_rd_en <= (state_next == irq_dequeue);
            tdma_event    <= (state == irq_decide) && is_tdma;
        end
    end

    // Head buffer address and its frame control
    always_ff @(posedge clk) begin
        if (state == irq_check_fifo && !rx_fifo_empty) begin
            buf_addr <= rx_fifo_data;
        end
        if (state == irq_rd_fctl && rd_done) begin
            fctl <= rd_data[15:0];
        end
    end

endmodule

// File: verilog/bus_master_arbiter.sv
`timescale 1ns/1ps

module bus_master_arbiter
    import desc_proc_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,

    // Read client
    input  logic                  rd_req,
    input  logic [data_width-1:0] rd_addr,
    output logic                  rd_done,
    output logic [data_width-1:0] rd_data,

    // Write client
    input  logic                  wr_req,
    input  logic [data_width-1:0] wr_addr,
    input  logic [data_width-1:0] wr_data,
    output logic                  wr_done,

    // Bus master port
    output logic                  mst_rd_req,
    output logic                  mst_wr_req,
    output logic [data_width-1:0] mst_addr,
    output logic [data_width-1:0] mst_wr_data,
    input  logic                  mst_cmdack,
    input  logic                  mst_cmplt,
    input  logic [data_width-1:0] mst_rd_data
);

    bus_op_t grant;
    logic    busy;
    logic    acked;
    logic    req_active;
    logic    bus_cmplt;

    assign req_active = mst_rd_req || mst_wr_req;
    // Completion only counts once the command was taken
    assign bus_cmplt  = req_active && mst_cmplt && (acked || mst_cmdack);

    // --------------------
    // Grant and handshake
    // --------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            grant      <= bus_read;
            busy       <= 1'b0;
            acked      <= 1'b0;
            mst_rd_req <= 1'b0;
            mst_wr_req <= 1'b0;
            rd_done    <= 1'b0;
            wr_done    <= 1'b0;
        end else begin
            rd_done <= 1'b0;
            wr_done <= 1'b0;
            if (!busy) begin
                // Reads win a tie
                if (rd_req) begin
                    grant      <= bus_read;
                    busy       <= 1'b1;
                    mst_rd_req <= 1'b1;
                end else if (wr_req) begin
                    grant      <= bus_write;
                    busy       <= 1'b1;
                    mst_wr_req <= 1'b1;
                end
            end else if (req_active) begin
                if (mst_cmdack) begin
                    acked <= 1'b1;
                end
                if (bus_cmplt) begin
                    mst_rd_req <= 1'b0;
                    mst_wr_req <= 1'b0;
                    acked      <= 1'b0;
                    rd_done    <= (grant == bus_read);
                    wr_done    <= (grant == bus_write);
                end
            end else begin
                // Done cycle, client sees it and moves on
                busy <= 1'b0;
            end
        end
    end

    // Address, write data and read data
    always_ff @(posedge clk) begin
        if (!busy) begin
            if (rd_req) begin
                mst_addr <= rd_addr;
            end else if (wr_req) begin
                mst_addr    <= wr_addr;
                mst_wr_data <= wr_data;
            end
        end
        if (bus_cmplt && grant == bus_read) begin
            rd_data <= mst_rd_data;
        end
    end

endmodule

// File: verilog/desc_processor.sv
`timescale 1ns/1ps

module desc_processor
    import desc_proc_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset_n,

    // Interrupts
    input  logic                  irq_in,
    output logic                  irq_out,
    output logic                  tdma_event,

    // Transmit descriptor FIFO
    input  logic                  tx_fifo_empty,
    input  logic [data_width-1:0] tx_fifo_data,
    output logic                  tx_fifo_rd_en,

    // Receive buffer FIFO
    input  logic                  rx_fifo_empty,
    input  logic [data_width-1:0] rx_fifo_data,
    output logic                  rx_fifo_rd_en,

    // Bus master port
    output logic                  mst_rd_req,
    output logic                  mst_wr_req,
    output logic [data_width-1:0] mst_addr,
    output logic [data_width-1:0] mst_wr_data,
    input  logic                  mst_cmdack,
    input  logic                  mst_cmplt,
    input  logic [data_width-1:0] mst_rd_data
);

    // --------------------
    // Client links
    // --------------------
    logic                  rd_req;
    logic [data_width-1:0] rd_addr;
    logic                  rd_done;
    logic [data_width-1:0] rd_data;

    logic                  wr_req;
    logic [data_width-1:0] wr_addr;
    logic [data_width-1:0] wr_data;
    logic                  wr_done;

    // Transmit register writes
    tx_desc_fetch u_tx_desc_fetch (
        .clk           (clk),
        .reset_n       (reset_n),
        .tx_fifo_empty (tx_fifo_empty),
        .tx_fifo_data  (tx_fifo_data),
        .tx_fifo_rd_en (tx_fifo_rd_en),
        .wr_req        (wr_req),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .wr_done       (wr_done)
    );

    // Receive interrupt filtering
    irq_filter u_irq_filter (
        .clk           (clk),
        .reset_n       (reset_n),
        .irq_in        (irq_in),
        .irq_out       (irq_out),
        .tdma_event    (tdma_event),
        .rx_fifo_empty (rx_fifo_empty),
        .rx_fifo_data  (rx_fifo_data),
        .rx_fifo_rd_en (rx_fifo_rd_en),
        .rd_req        (rd_req),
        .rd_addr       (rd_addr),
        .rd_done       (rd_done),
        .rd_data       (rd_data)
    );

    bus_master_arbiter u_bus_master_arbiter (
        .clk         (clk),
        .reset_n     (reset_n),
        .rd_req      (rd_req),
        .rd_addr     (rd_addr),
        .rd_done     (rd_done),
        .rd_data     (rd_data),
        .wr_req      (wr_req),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .wr_done     (wr_done),
        .mst_rd_req  (mst_rd_req),
        .mst_wr_req  (mst_wr_req),
        .mst_addr    (mst_addr),
        .mst_wr_data (mst_wr_data),
        .mst_cmdack  (mst_cmdack),
        .mst_cmplt   (mst_cmplt),
        .mst_rd_data (mst_rd_data)
    );

endmodule

// File: tests/desc_processor_assertions.sv
`timescale 1ns/1ps

module desc_processor_assertions
    import desc_proc_pkg::*;
(
    input logic                  clk,
    input logic                  reset_n,
    input logic                  irq_in,
    input logic                  irq_out,
    input logic                  mst_rd_req,
    input logic                  mst_wr_req,
    input logic [data_width-1:0] mst_addr,
    input logic [data_width-1:0] mst_wr_data,
    input logic                  mst_cmplt
);

    // Count of assertion failures
    int unsigned error_count = 0;

    logic    req_high;
    bus_op_t req_op;

    assign req_high = mst_rd_req || mst_wr_req;
    assign req_op   = mst_wr_req ? bus_write : bus_read;

    // --------------------
    // Bus handshake
    // --------------------
    one_request: assert property (@(posedge clk) disable iff (!reset_n)
        !(mst_rd_req && mst_wr_req))
    else begin
        error_count++;
        $error("mst_rd_req and mst_wr_req high together");
    end

    // Request, opcode and address hold until completion
    req_held: assert property (@(posedge clk) disable iff (!reset_n)
        req_high && !mst_cmplt |=> req_high && $stable(req_op) && $stable(mst_addr))
    else begin
        error_count++;
        $error("bus request dropped or changed before mst_cmplt");
    end

    wr_data_held: assert property (@(posedge clk) disable iff (!reset_n)
        mst_wr_req && !mst_cmplt |=> $stable(mst_wr_data))
    else begin
        error_count++;
        $error("mst_wr_data changed during a write");
    end

    req_release: assert property (@(posedge clk) disable iff (!reset_n)
        req_high && mst_cmplt |=> !req_high)
    else begin
        error_count++;
        $error("bus request still high after mst_cmplt");
    end

    req_fall: assert property (@(posedge clk) disable iff (!reset_n)
        $fell(req_high) |-> $past(mst_cmplt))
    else begin
        error_count++;
        $error("bus request fell without mst_cmplt");
    end

    // --------------------
    // Reset and host interrupt
    // --------------------
    reset_quiet: assert property (@(posedge clk)
        !reset_n |-> !irq_out && !req_high)
    else begin
        error_count++;
        $error("irq_out or a bus request high during reset");
    end

    // Host interrupt stays up while the radio still holds irq_in
    irq_hold: assert property (@(posedge clk) disable iff (!reset_n)
        irq_out && irq_in |=> irq_out)
    else begin
        error_count++;
        $error("irq_out fell while irq_in was still high");
    end

    irq_release: assert property (@(posedge clk) disable iff (!reset_n)
        irq_out && !irq_in |=> !irq_out)
    else begin
        error_count++;
        $error("irq_out did not follow irq_in low");
    end

endmodule

bind desc_processor desc_processor_assertions u_assertions (
    .clk         (clk),
    .reset_n     (reset_n),
    .irq_in      (irq_in),
    .irq_out     (irq_out),
    .mst_rd_req  (mst_rd_req),
    .mst_wr_req  (mst_wr_req),
    .mst_addr    (mst_addr),
    .mst_wr_data (mst_wr_data),
    .mst_cmplt   (mst_cmplt)
);

// File: tests/tb_desc_processor.sv
`timescale 1ns/1ps

module tb_desc_processor
    import desc_proc_pkg::*;
();

    localparam int clk_period     = 8;
    localparam int tx_pairs_first = 6;
    localparam int tx_pairs_mixed = 4;
    localparam int irq_cases      = 5;
    localparam int test_steps     = tx_pairs_first + tx_pairs_mixed + irq_cases;

    logic                  clk;
    logic                  reset_n;
    logic                  irq_in;
    logic                  irq_out;
    logic                  tdma_event;
    logic                  tx_fifo_empty;
    logic [data_width-1:0] tx_fifo_data;
    logic                  tx_fifo_rd_en;
    logic                  rx_fifo_empty;
    logic [data_width-1:0] rx_fifo_data;
    logic                  rx_fifo_rd_en;
    logic                  mst_rd_req;
    logic                  mst_wr_req;
    logic [data_width-1:0] mst_addr;
    logic [data_width-1:0] mst_wr_data;
    logic                  mst_cmdack;
    logic                  mst_cmplt;
    logic [data_width-1:0] mst_rd_data;

    // FIFO contents, expected traffic and slave memory
    logic [data_width-1:0]   tx_q[$];
    logic [data_width-1:0]   rx_q[$];
    logic [2*data_width-1:0] exp_writes[$];
    logic [data_width-1:0]   exp_reads[$];
    logic [data_width-1:0]   mem[logic [data_width-1:0]];

    int seed        = 32'h2469e614;
    int rx_pops     = 0;
    int tdma_pulses = 0;

    desc_processor DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("=== FAIL ===");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_value(input string name, input logic [data_width-1:0] got,
                               input logic [data_width-1:0] expected);
        assert (got === expected) else begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, expected);
            stop_with_failure();
        end
    endtask

    // --------------------
    // FIFO models
    // --------------------
    always @(negedge clk) begin
        if (tx_fifo_rd_en) begin
            assert (tx_q.size() != 0) else begin
                $display("tx_fifo_rd_en pulsed while the transmit FIFO was empty");
                stop_with_failure();
            end
            void'(tx_q.pop_front());
        end
        if (rx_fifo_rd_en) begin
            assert (rx_q.size() != 0) else begin
                $display("rx_fifo_rd_en pulsed while the receive FIFO was empty");
                stop_with_failure();
            end
            void'(rx_q.pop_front());
            rx_pops++;
        end
        if (tdma_event) begin
            tdma_pulses++;
        end
        tx_fifo_empty = (tx_q.size() == 0);
        tx_fifo_data  = (tx_q.size() != 0) ? tx_q[0] : '0;
        rx_fifo_empty = (rx_q.size() == 0);
        rx_fifo_data  = (rx_q.size() != 0) ? rx_q[0] : '0;
    end

    // --------------------
    // Bus slave
    // --------------------
    initial begin : bus_slave
        int                      ack_wait;
        int                      cmplt_wait;
        logic [2*data_width-1:0] expected;
        forever begin
            @(negedge clk);
            if (mst_rd_req || mst_wr_req) begin
                ack_wait   = $unsigned($random(seed)) % 4;
                cmplt_wait = $unsigned($random(seed)) % 4;
                repeat (ack_wait) @(negedge clk);
                mst_cmdack = 1'b1;
                repeat (cmplt_wait) begin
                    @(negedge clk);
                    mst_cmdack = 1'b0;
                end
                mst_cmplt = 1'b1;
                if (mst_wr_req) begin
                    assert (exp_writes.size() != 0) else begin
                        $display("Bus write to 0x%h was not expected", mst_addr);
                        stop_with_failure();
                    end
                    expected = exp_writes.pop_front();
                    check_value("mst_addr", mst_addr, expected[2*data_width-1:data_width]);
                    check_value("mst_wr_data", mst_wr_data, expected[data_width-1:0]);
                    mem[mst_addr] = mst_wr_data;
                end else begin
                    assert (exp_reads.size() != 0) else begin
                        $display("Bus read from 0x%h was not expected", mst_addr);
                        stop_with_failure();
                    end
                    check_value("mst_addr", mst_addr, exp_reads.pop_front());
                    mst_rd_data = mem.exists(mst_addr) ? mem[mst_addr] : '0;
                end
                @(negedge clk);
                mst_cmdack = 1'b0;
                mst_cmplt  = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        if (DUT.u_assertions.error_count != 0) begin
            $display("A bound handshake or irq_out assertion failed");
            stop_with_failure();
        end
    end

    initial begin : watchdog
        #(test_steps * 200 * clk_period);
        $display("Timeout, the run did not finish within %0d cycles", test_steps * 200);
        stop_with_failure();
    end

    // --------------------
    // Stimulus helpers
    // --------------------
    task automatic push_random_pairs(input int count);
        logic [data_width-1:0] addr;
        logic [data_width-1:0] data;
        for (int i = 0; i < count; i++) begin
            addr = 32'h7000_0000 | ($random(seed) & 32'h0000_fffc);
            data = $random(seed);
            tx_q.push_back(addr);
            tx_q.push_back(data);
            exp_writes.push_back({addr, data});
        end
    endtask

    task automatic wait_writes_drained();
        while (exp_writes.size() != 0 || tx_q.size() != 0) @(negedge clk);
    endtask

    task automatic setup_buffer(input logic [data_width-1:0] base,
                                input logic [data_width-1:0] status,
                                input logic [data_width-1:0] fctl_word);
        mem[base + rx_status_offset] = status;
        mem[base + rx_fctl_offset]   = fctl_word;
    endtask

    // Raise irq_in, wait for the host interrupt, then release it
    task automatic filter_interrupt(input int exp_pops, input int exp_tdma);
        int pops_before;
        int tdma_before;
        pops_before = rx_pops;
        tdma_before = tdma_pulses;
        irq_in = 1'b1;
        while (irq_out !== 1'b1) @(negedge clk);
        assert (exp_reads.size() == 0) else begin
            $display("irq_out rose before all expected register reads were made");
            stop_with_failure();
        end
        check_value("rx_fifo_rd_en pops", rx_pops - pops_before, exp_pops);
        check_value("tdma_event pulses", tdma_pulses - tdma_before, exp_tdma);
        // Keep the radio interrupt up a few cycles with irq_out high
        repeat (3) @(negedge clk);
        irq_in = 1'b0;
        while (irq_out !== 1'b0) @(negedge clk);
        repeat (2) @(negedge clk);
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin : main
        logic [data_width-1:0] tdma_fctl;
        logic [data_width-1:0] data_fctl;
        reset_n       = 1'b0;
        irq_in        = 1'b0;
        tx_fifo_empty = 1'b1;
        tx_fifo_data  = '0;
        rx_fifo_empty = 1'b1;
        rx_fifo_data  = '0;
        mst_cmdack    = 1'b0;
        mst_cmplt     = 1'b0;
        mst_rd_data   = '0;
        // Flag bits above the type field must be ignored
        tdma_fctl = 32'h0000_1100 | {16'h0000, fctl_tdma_value};
        data_fctl = 32'h0000_0008;
        repeat (3) @(negedge clk);
        reset_n = 1'b1;
        @(negedge clk);

        // Transmit pairs alone
        push_random_pairs(tx_pairs_first);
        wait_writes_drained();

        // Cause without MAC bit leaves the waiting buffer in place
        mem[async_cause_addr] = 32'h0000_0100;
        setup_buffer(32'h1000_0000, rx_done_mask, data_fctl);
        rx_q.push_back(32'h1000_0000);
        exp_reads.push_back(async_cause_addr);
        filter_interrupt(0, 0);
        rx_q.delete();

        // TDMA buffer swallowed, data buffer passes
        mem[async_cause_addr] = mac_irq_mask;
        mem[isr_addr]         = 32'h0000_0001;
        setup_buffer(32'h1000_0100, rx_done_mask, tdma_fctl);
        setup_buffer(32'h1000_0200, rx_done_mask, data_fctl);
        rx_q.push_back(32'h1000_0100);
        rx_q.push_back(32'h1000_0200);
        exp_reads = '{async_cause_addr, isr_addr,
                      32'h1000_0100 + rx_status_offset, 32'h1000_0100 + rx_fctl_offset,
                      32'h1000_0200 + rx_status_offset, 32'h1000_0200 + rx_fctl_offset};
        filter_interrupt(2, 1);

        // TDMA buffer swallowed, then FIFO empty
        mem[isr_addr] = 32'h0000_0002;
        setup_buffer(32'h1000_0300, rx_done_mask, tdma_fctl);
        rx_q.push_back(32'h1000_0300);
        exp_reads = '{async_cause_addr, isr_addr,
                      32'h1000_0300 + rx_status_offset, 32'h1000_0300 + rx_fctl_offset};
        filter_interrupt(1, 1);

        // Receive not done yet
        setup_buffer(32'h1000_0400, 32'h8000_0000, tdma_fctl);
        rx_q.push_back(32'h1000_0400);
        exp_reads = '{async_cause_addr, isr_addr, 32'h1000_0400 + rx_status_offset};
        filter_interrupt(0, 0);
        rx_q.delete();

        // Writes and filtering share the bus
        push_random_pairs(tx_pairs_mixed);
        setup_buffer(32'h1000_0500, rx_done_mask, tdma_fctl);
        setup_buffer(32'h1000_0600, rx_done_mask, data_fctl);
        rx_q.push_back(32'h1000_0500);
        rx_q.push_back(32'h1000_0600);
        exp_reads = '{async_cause_addr, isr_addr,
                      32'h1000_0500 + rx_status_offset, 32'h1000_0500 + rx_fctl_offset,
                      32'h1000_0600 + rx_status_offset, 32'h1000_0600 + rx_fctl_offset};
        filter_interrupt(2, 1);
        wait_writes_drained();

        repeat (4) @(negedge clk);
        if (DUT.u_assertions.error_count != 0) begin
            $display("Bound assertions reported %0d failures", DUT.u_assertions.error_count);
            stop_with_failure();
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

// File: desc_processor.f
verilog/desc_proc_pkg.sv
verilog/tx_desc_fetch.sv
verilog/irq_filter.sv
verilog/bus_master_arbiter.sv
verilog/desc_processor.sv
tests/desc_processor_assertions.sv
tests/tb_desc_processor.sv

// File: Makefile
# Verilator build and run of the descriptor processor testbench

VERILATOR ?= verilator
TOP       ?= tb_desc_processor
FILELIST  ?= desc_processor.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+10
PASS_TEXT ?= === PASS ===

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS SIM_ARGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -qF -- "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
